// File: hw/pe_column.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module pe_column (
    input  logic                clock,
    input  logic                reset,
    input  logic                lhs_valid,
    input  spmm_pkg::idx_t      lhs_col [`SPMM_N-1:0],
    input  spmm_pkg::data_t     lhs_data [`SPMM_N-1:0],
    input  spmm_pkg::data_t     rhs_col [`SPMM_N-1:0],
    input  logic [`SPMM_N-1:0]  lane_valid,
    input  spmm_pkg::idx_t      lane_row [`SPMM_N-1:0],
    input  logic [`SPMM_N-1:0]  lane_end,
    input  logic                stage_valid,
    input  logic                stage_first,
    output logic [`SPMM_N-1:0]  wr_en,
    output spmm_pkg::idx_t      wr_row [`SPMM_N-1:0],
    output spmm_pkg::data_t     wr_data [`SPMM_N-1:0]
);
    import spmm_pkg::*;

    data_t  prod_q [`SPMM_N-1:0];
    data_t  masked [`SPMM_N-1:0];
    data_t  seg_sum [`SPMM_N-1:0];
    data_t  halo_q;
    data_t  halo_in;
    data_t  halo_out;

    // Products wrap to W bits, same as the final sums
    always_ff @(posedge clock) begin
        if (lhs_valid) begin
            for (int i = 0; i < `SPMM_N; i++) begin
                prod_q[i] <= lhs_data[i] * rhs_col[lhs_col[i]];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SPMM_N; i++) begin
            masked[i] = lane_valid[i] ? prod_q[i] : '0;
        end
    end

    // A new job never inherits the previous job's carry
    assign halo_in = stage_first ? '0 : halo_q;

    segmented_reducer u_segmented_reducer (
        .products (masked),
        .lane_end (lane_end),
        .halo_in  (halo_in),
        .seg_sum  (seg_sum),
        .halo_out (halo_out)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_en  <= '0;
            halo_q <= '0;
        end else begin
            wr_en <= stage_valid ? (lane_valid & lane_end) : '0;
            if (stage_valid)
                halo_q <= halo_out;
        end
    end

    always_ff @(posedge clock) begin
        if (stage_valid) begin
            wr_row  <= lane_row;
            wr_data <= seg_sum;
        end
    end

endmodule

`default_nettype wire

// File: hw/result_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module result_buffer (
    input  logic                clock,
    input  logic                reset,
    input  logic                clear_results,
    input  logic [`SPMM_N-1:0]  wr_en [`SPMM_N-1:0],
    input  spmm_pkg::idx_t      wr_row [`SPMM_N-1:0][`SPMM_N-1:0],
    input  spmm_pkg::data_t     wr_data [`SPMM_N-1:0][`SPMM_N-1:0],
    input  spmm_pkg::block_t    out_block,
    output spmm_pkg::data_t     out_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0]
);
    import spmm_pkg::*;

    // Indexed by row then column
    data_t store [`SPMM_N-1:0][`SPMM_N-1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            store <= '{default: '0};
        end else if (clear_results) begin
            // Rows that never get a write stay zero
            store <= '{default: '0};
        end else begin
            for (int c = 0; c < `SPMM_N; c++) begin
                for (int l = 0; l < `SPMM_N; l++) begin
                    if (wr_en[c][l])
                        store[wr_row[c][l]][c] <= wr_data[c][l];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `SPMM_BLOCK_ROWS; r++) begin
            for (int c = 0; c < `SPMM_N; c++) begin
                out_data[r][c] = store[int'(out_block) * `SPMM_BLOCK_ROWS + r][c];
            end
        end
    end

    // Each row ends at exactly one lane, so one writer per row and column
    for (genvar c = 0; c < `SPMM_N; c++) begin : g_col_check
        for (genvar a = 0; a < `SPMM_N; a++) begin : g_lane_a
            for (genvar b = a + 1; b < `SPMM_N; b++) begin : g_lane_b
                single_writer_a: assert property (
                    @(posedge clock) disable iff (reset)
                    !(wr_en[c][a] && wr_en[c][b] && wr_row[c][a] == wr_row[c][b])
                );
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rhs_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module rhs_buffer (
    input  logic              clock,
    input  logic              rhs_wr,
    input  spmm_pkg::block_t  rhs_block,
    input  spmm_pkg::data_t   rhs_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0],
    output spmm_pkg::data_t   rhs_cols [`SPMM_N-1:0][`SPMM_N-1:0]
);

    // Stored transposed so each column is one contiguous slice
    always_ff @(posedge clock) begin
        if (rhs_wr) begin
            for (int r = 0; r < `SPMM_BLOCK_ROWS; r++) begin
                for (int c = 0; c < `SPMM_N; c++) begin
                    rhs_cols[c][int'(rhs_block) * `SPMM_BLOCK_ROWS + r] <= rhs_data[r][c];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/row_split_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module row_split_decoder (
    input  logic                clock,
    input  logic                reset,
    input  logic                lhs_valid,
    input  spmm_pkg::ptr_t      lhs_ptr [`SPMM_N-1:0],
    input  spmm_pkg::idx_t      chunk_idx,
    input  logic                first_chunk,
    output logic [`SPMM_N-1:0]  lane_valid,
    output spmm_pkg::idx_t      lane_row [`SPMM_N-1:0],
    output logic [`SPMM_N-1:0]  lane_end,
    output logic                stage_valid,
    output logic                stage_first
);
    import spmm_pkg::*;

    logic [`SPMM_N-1:0]  next_valid;
    idx_t                next_row [`SPMM_N-1:0];
    logic [`SPMM_N-1:0]  next_end;

    always_comb begin
        ptr_t pos;
        for (int i = 0; i < `SPMM_N; i++) begin
            // Global nonzero position of this lane
            pos = ptr_t'({chunk_idx, idx_t'(i)});
            next_valid[i] = pos < lhs_ptr[`SPMM_N-1];
            next_row[i] = '0;
            next_end[i] = 1'b0;
            for (int j = 0; j < `SPMM_N; j++) begin
                // Rows already finished at or before pos, empty rows included
                if (lhs_ptr[j] <= pos)
                    next_row[i] = next_row[i] + 1'b1;
                if (lhs_ptr[j] == pos + 1'b1)
                    next_end[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage_valid <= 1'b0;
            stage_first <= 1'b0;
        end else begin
            stage_valid <= lhs_valid;
            if (lhs_valid)
                stage_first <= first_chunk;
        end
    end

    always_ff @(posedge clock) begin
        if (lhs_valid) begin
            lane_valid <= next_valid;
            lane_row   <= next_row;
            lane_end   <= next_end;
        end
    end

    for (genvar j = 1; j < `SPMM_N; j++) begin : g_ptr_check
        ptr_order_a: assert property (
            @(posedge clock) disable iff (reset) lhs_valid |-> lhs_ptr[j] >= lhs_ptr[j-1]
        );
    end

endmodule

`default_nettype wire

// File: hw/segmented_reducer.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module segmented_reducer (
    input  spmm_pkg::data_t     products [`SPMM_N-1:0],
    input  logic [`SPMM_N-1:0]  lane_end,
    input  spmm_pkg::data_t     halo_in,
    output spmm_pkg::data_t     seg_sum [`SPMM_N-1:0],
    output spmm_pkg::data_t     halo_out
);
    import spmm_pkg::*;

    // Single level scan, short enough for N lanes in one cycle
    always_comb begin
        data_t run;
        run = halo_in;
        for (int i = 0; i < `SPMM_N; i++) begin
            run = run + products[i];
            seg_sum[i] = run;
            // Next lane opens a new row
            if (lane_end[i])
                run = '0;
        end
        // Zero when the last lane closed its row
        halo_out = run;
    end

endmodule

`default_nettype wire

// File: hw/spmm_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module spmm_control (
    input  logic              clock,
    input  logic              reset,
    input  logic              rhs_start,
    input  logic              lhs_valid,
    input  spmm_pkg::ptr_t    nnz_count,
    input  logic              out_start,
    output logic              rhs_ready,
    output logic              lhs_ready,
    output logic              out_ready,
    output logic              rhs_wr,
    output spmm_pkg::block_t  rhs_block,
    output spmm_pkg::idx_t    chunk_idx,
    output logic              first_chunk,
    output logic              clear_results,
    output spmm_pkg::block_t  out_block
);
    import spmm_pkg::*;

    localparam int DRAIN_W = $clog2(`SPMM_PIPE_DEPTH + 1);

    spmm_state_t         state;
    spmm_state_t         next_state;
    block_t              load_cnt;
    idx_t                chunk_cnt;
    logic [DRAIN_W-1:0]  drain_cnt;
    block_t              out_cnt;
    ptr_t                last_chunk;
    logic                load_last;
    logic                chunk_last;
    logic                drain_done;
    logic                out_last;

    // ceil(nnz/N) - 1, every job has at least one nonzero
    assign last_chunk = (nnz_count - 1'b1) >> `SPMM_LG_N;

    // Block 0 comes with the start strobe, the rest back to back
    assign rhs_wr     = (state == IDLE && rhs_start) || state == LOAD_RHS;
    assign load_last  = rhs_wr && load_cnt == block_t'(`SPMM_NUM_BLOCKS - 1);
    assign chunk_last = state == COMPUTE && lhs_valid && ptr_t'(chunk_cnt) == last_chunk;
    assign drain_done = state == DRAIN && drain_cnt == DRAIN_W'(`SPMM_PIPE_DEPTH);
    assign out_last   = state == OUTPUT && out_start && out_cnt == block_t'(`SPMM_NUM_BLOCKS - 1);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (load_last)
                    next_state = COMPUTE;
                else if (rhs_start)
                    next_state = LOAD_RHS;
            end
            LOAD_RHS: if (load_last) next_state = COMPUTE;
            COMPUTE:  if (chunk_last) next_state = DRAIN;
            DRAIN:    if (drain_done) next_state = OUTPUT;
            OUTPUT:   if (out_last) next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            load_cnt  <= '0;
            chunk_cnt <= '0;
            drain_cnt <= '0;
            out_cnt   <= '0;
        end else begin
            state <= next_state;

            if (load_last)
                load_cnt <= '0;
            else if (rhs_wr)
                load_cnt <= load_cnt + 1'b1;

            if (state != COMPUTE)
                chunk_cnt <= '0;
            else if (lhs_valid)
                chunk_cnt <= chunk_cnt + 1'b1;

            if (state == DRAIN)
                drain_cnt <= drain_cnt + 1'b1;
            else
                drain_cnt <= '0;

            // Block index only moves when the consumer takes it
            if (out_last)
                out_cnt <= '0;
            else if (state == OUTPUT && out_start)
                out_cnt <= out_cnt + 1'b1;
        end
    end

    assign rhs_ready     = state == IDLE;
    assign lhs_ready     = state == COMPUTE;
    assign out_ready     = state == OUTPUT;
    assign rhs_block     = load_cnt;
    assign chunk_idx     = chunk_cnt;
    assign first_chunk   = chunk_cnt == '0;
    assign clear_results = load_last;
    assign out_block     = out_cnt;

    lhs_valid_in_compute_a: assert property (
        @(posedge clock) disable iff (reset) lhs_valid |-> state == COMPUTE
    );

    rhs_start_in_idle_a: assert property (
        @(posedge clock) disable iff (reset) rhs_start |-> state == IDLE
    );

endmodule

`default_nettype wire

// File: hw/spmm_pkg.sv
`default_nettype none

`include "spmm_defines.svh"

package spmm_pkg;

    typedef logic [`SPMM_W-1:0] data_t;
    typedef logic [`SPMM_LG_N-1:0] idx_t;
    typedef logic [`SPMM_PTR_W-1:0] ptr_t;

    // At least one bit even for a single block
    typedef logic [(`SPMM_NUM_BLOCKS > 1 ? $clog2(`SPMM_NUM_BLOCKS) : 1)-1:0] block_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_RHS,
        COMPUTE,
        DRAIN,
        OUTPUT
    } spmm_state_t;

endpackage

`default_nettype wire

// File: hw/spmm_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module spmm_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              rhs_start,
    input  spmm_pkg::data_t   rhs_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0],
    input  logic              lhs_valid,
    input  spmm_pkg::ptr_t    lhs_ptr [`SPMM_N-1:0],
    input  spmm_pkg::idx_t    lhs_col [`SPMM_N-1:0],
    input  spmm_pkg::data_t   lhs_data [`SPMM_N-1:0],
    input  logic              out_start,
    output logic              rhs_ready,
    output logic              lhs_ready,
    output logic              out_ready,
    output spmm_pkg::block_t  out_block,
    output spmm_pkg::data_t   out_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0]
);
    import spmm_pkg::*;

    logic                rhs_wr;
    block_t              rhs_block;
    idx_t                chunk_idx;
    logic                first_chunk;
    logic                clear_results;
    data_t               rhs_cols [`SPMM_N-1:0][`SPMM_N-1:0];

    // Decoder outputs shared by all columns
    logic [`SPMM_N-1:0]  lane_valid;
    idx_t                lane_row [`SPMM_N-1:0];
    logic [`SPMM_N-1:0]  lane_end;
    logic                stage_valid;
    logic                stage_first;

    // Write requests, indexed by column then lane
    logic [`SPMM_N-1:0]  wr_en [`SPMM_N-1:0];
    idx_t                wr_row [`SPMM_N-1:0][`SPMM_N-1:0];
    data_t               wr_data [`SPMM_N-1:0][`SPMM_N-1:0];

    spmm_control u_spmm_control (
        .clock         (clock),
        .reset         (reset),
        .rhs_start     (rhs_start),
        .lhs_valid     (lhs_valid),
        .nnz_count     (lhs_ptr[`SPMM_N-1]),
        .out_start     (out_start),
        .rhs_ready     (rhs_ready),
        .lhs_ready     (lhs_ready),
        .out_ready     (out_ready),
        .rhs_wr        (rhs_wr),
        .rhs_block     (rhs_block),
        .chunk_idx     (chunk_idx),
        .first_chunk   (first_chunk),
        .clear_results (clear_results),
        .out_block     (out_block)
    );

    rhs_buffer u_rhs_buffer (
        .clock     (clock),
        .rhs_wr    (rhs_wr),
        .rhs_block (rhs_block),
        .rhs_data  (rhs_data),
        .rhs_cols  (rhs_cols)
    );

    row_split_decoder u_row_split_decoder (
        .clock       (clock),
        .reset       (reset),
        .lhs_valid   (lhs_valid),
        .lhs_ptr     (lhs_ptr),
        .chunk_idx   (chunk_idx),
        .first_chunk (first_chunk),
        .lane_valid  (lane_valid),
        .lane_row    (lane_row),
        .lane_end    (lane_end),
        .stage_valid (stage_valid),
        .stage_first (stage_first)
    );

    // One processing column per result column
    for (genvar c = 0; c < `SPMM_N; c++) begin : g_col
        pe_column u_pe_column (
            .clock       (clock),
            .reset       (reset),
            .lhs_valid   (lhs_valid),
            .lhs_col     (lhs_col),
            .lhs_data    (lhs_data),
            .rhs_col     (rhs_cols[c]),
            .lane_valid  (lane_valid),
            .lane_row    (lane_row),
            .lane_end    (lane_end),
            .stage_valid (stage_valid),
            .stage_first (stage_first),
            .wr_en       (wr_en[c]),
            .wr_row      (wr_row[c]),
            .wr_data     (wr_data[c])
        );
    end

    result_buffer u_result_buffer (
        .clock         (clock),
        .reset         (reset),
        .clear_results (clear_results),
        .wr_en         (wr_en),
        .wr_row        (wr_row),
        .wr_data       (wr_data),
        .out_block     (out_block),
        .out_data      (out_data)
    );

endmodule

`default_nettype wire

// File: include/spmm_defines.svh
`ifndef SPMM_DEFINES_SVH
`define SPMM_DEFINES_SVH

// Matrix dimension, also the lane count per chunk
`define SPMM_N 4
`define SPMM_W 8
`define SPMM_LG_N 2

// Wide enough to hold N*N nonzeros
`define SPMM_PTR_W 5

// Rows per RHS load block and per output block
`define SPMM_BLOCK_ROWS 2
`define SPMM_NUM_BLOCKS 2

// Chunk acceptance to result store write
`define SPMM_PIPE_DEPTH 2

`endif

// File: tb.f
+incdir+include
hw/spmm_pkg.sv
hw/rhs_buffer.sv
hw/row_split_decoder.sv
hw/segmented_reducer.sv
hw/pe_column.sv
hw/result_buffer.sv
hw/spmm_control.sv
hw/spmm_top.sv
testbench/spmm_checker.sv
testbench/tb_spmm.sv

// File: testbench/spmm_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module spmm_checker (
    input  logic              clock,
    input  logic              reset,
    input  logic              rhs_ready,
    input  logic              lhs_ready,
    input  logic              out_ready,
    input  logic              out_start,
    input  spmm_pkg::block_t  out_block,
    input  spmm_pkg::data_t   out_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0],
    input  int                job_num,
    input  spmm_pkg::data_t   expected [`SPMM_N-1:0][`SPMM_N-1:0],
    output int                error_count,
    output int                jobs_done,
    output int                blocks_done
);
    import spmm_pkg::*;

    int      next_block;
    int      job_errors;
    int      done_job;
    logic    in_reset;
    logic    check_idle;
    logic    held;
    block_t  held_block;
    data_t   held_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0];

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("FAIL %s: got %h expected %h", name, got, exp);
        error_count++;
        job_errors++;
    endtask

    // Levels expected whenever the DUT sits idle
    task automatic check_levels(input string when);
        if (rhs_ready !== 1'b1)
            report($sformatf("rhs_ready %s", when), rhs_ready, 1);
        if (lhs_ready !== 1'b0)
            report($sformatf("lhs_ready %s", when), lhs_ready, 0);
        if (out_ready !== 1'b0)
            report($sformatf("out_ready %s", when), out_ready, 0);
    endtask

    // Sampled mid cycle, inputs and outputs are settled here
    always @(negedge clock) begin
        if (reset) begin
            error_count = 0;
            jobs_done = 0;
            blocks_done = 0;
            next_block = 0;
            job_errors = 0;
            done_job = 0;
            in_reset = 1'b1;
            check_idle = 1'b0;
            held = 1'b0;
        end else begin
            if (in_reset) begin
                check_levels("after reset");
                in_reset = 1'b0;
            end
            if (check_idle) begin
                check_levels($sformatf("after job %0d", done_job));
                $display("job %0d finished with %0d errors", done_job, job_errors);
                jobs_done++;
                job_errors = 0;
                check_idle = 1'b0;
            end
            // A block on hold must not move
            if (held) begin
                if (out_block !== held_block)
                    report("out_block while held", out_block, held_block);
                for (int r = 0; r < `SPMM_BLOCK_ROWS; r++) begin
                    for (int c = 0; c < `SPMM_N; c++) begin
                        if (out_data[r][c] !== held_data[r][c])
                            report($sformatf("out_data[%0d][%0d] held block %0d", r, c,
                                   held_block), out_data[r][c], held_data[r][c]);
                    end
                end
            end
            held = 1'b0;
            if (out_ready && out_start) begin
                if (out_block !== block_t'(next_block))
                    report("out_block", out_block, next_block);
                for (int r = 0; r < `SPMM_BLOCK_ROWS; r++) begin
                    for (int c = 0; c < `SPMM_N; c++) begin
                        if (out_data[r][c] !== expected[next_block * `SPMM_BLOCK_ROWS + r][c])
                            report($sformatf("out_data[%0d][%0d] block %0d", r, c, next_block),
                                   out_data[r][c],
                                   expected[next_block * `SPMM_BLOCK_ROWS + r][c]);
                    end
                end
                blocks_done++;
                if (next_block == `SPMM_NUM_BLOCKS - 1) begin
                    next_block = 0;
                    done_job = job_num;
                    check_idle = 1'b1;
                end else begin
                    next_block++;
                end
            end else if (out_ready) begin
                held = 1'b1;
                held_block = out_block;
                held_data = out_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/spmm_patterns.hex
// Per job: N row lengths, then per chunk N column indices and N values,
// then N RHS rows and N expected result rows, N entries each
// job 1, fully dense
04 04 04 04
00 01 02 03 01 02 03 04
00 01 02 03 10 20 30 40
00 01 02 03 ff 00 01 80
00 01 02 03 05 06 07 08
01 00 02 03
04 05 06 07
08 09 0a 0b
0c 0d 0e 0f
51 59 64 6e
10 90 40 e0
07 89 08 88
b5 c5 e4 fe
// job 2, rows cross chunk boundaries
03 06 05 02
00 02 03 00 01 02 03 04
01 02 03 00 05 06 07 08
01 01 02 03 09 02 03 04
00 02 03 01 05 06 0a 0b
10 20 30 40
01 01 01 01
02 03 05 07
ff 80 00 11
11 a6 3a 81
d3 20 6c af
60 bd 1f c5
01 0b 0b b5
// job 3, empty first row and rows ending back to back
00 05 00 03
00 01 02 03 02 03 04 05
01 02 00 03 06 20 ff 40
03 00 00 01
00 05 00 02
07 00 09 00
01 02 03 04
00 00 00 00
27 37 33 28
00 00 00 00
1d 80 e0 ff
// job 4, seven nonzeros, last lane masked
02 01 03 01
01 03 02 00 03 02 01 01
01 03 00 01 10 04 02 99
11 22 33 44
01 02 03 04
80 40 20 10
00 ff 00 ff
03 04 09 0a
80 40 20 10
21 3e 63 80
22 44 66 88
// job 5, ten nonzeros, empty middle row
01 00 04 05
03 00 01 02 80 01 02 03
03 00 01 02 04 05 06 07
03 00 03 02 08 09 77 aa
02 02 02 02
03 00 01 00
00 04 00 05
06 07 08 09
00 80 00 80
00 00 00 00
20 2a 24 35
5e 70 62 87

// File: testbench/tb_spmm.sv
`timescale 1ns/100ps
`default_nettype none

`include "spmm_defines.svh"

module tb_spmm;
    import spmm_pkg::*;

    localparam int NUM_JOBS = 5;
    localparam int PAT_DEPTH = 512;
    localparam int DRIVE_DELAY = 10;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * (`SPMM_NUM_BLOCKS + `SPMM_N
        + `SPMM_PIPE_DEPTH + 1 + `SPMM_NUM_BLOCKS * 16) * 4;

    logic    clock;
    logic    reset;
    logic    rhs_start;
    logic    lhs_valid;
    logic    out_start;
    logic    rhs_ready;
    logic    lhs_ready;
    logic    out_ready;
    data_t   rhs_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0];
    ptr_t    lhs_ptr [`SPMM_N-1:0];
    idx_t    lhs_col [`SPMM_N-1:0];
    data_t   lhs_data [`SPMM_N-1:0];
    block_t  out_block;
    data_t   out_data [`SPMM_BLOCK_ROWS-1:0][`SPMM_N-1:0];

    logic [7:0]   patterns [0:PAT_DEPTH-1];
    int           pat_pos;
    data_t        rhs_mat [`SPMM_N-1:0][`SPMM_N-1:0];
    data_t        expected [`SPMM_N-1:0][`SPMM_N-1:0];
    int           job_num;
    int           error_count;
    int           jobs_done;
    int           blocks_done;
    logic [31:0]  lfsr;

    spmm_top u_spmm_top (
        .clock     (clock),
        .reset     (reset),
        .rhs_start (rhs_start),
        .rhs_data  (rhs_data),
        .lhs_valid (lhs_valid),
        .lhs_ptr   (lhs_ptr),
        .lhs_col   (lhs_col),
        .lhs_data  (lhs_data),
        .out_start (out_start),
        .rhs_ready (rhs_ready),
        .lhs_ready (lhs_ready),
        .out_ready (out_ready),
        .out_block (out_block),
        .out_data  (out_data)
    );

    spmm_checker u_spmm_checker (
        .clock       (clock),
        .reset       (reset),
        .rhs_ready   (rhs_ready),
        .lhs_ready   (lhs_ready),
        .out_ready   (out_ready),
        .out_start   (out_start),
        .out_block   (out_block),
        .out_data    (out_data),
        .job_num     (job_num),
        .expected    (expected),
        .error_count (error_count),
        .jobs_done   (jobs_done),
        .blocks_done (blocks_done)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bit(output logic value);
        lfsr = lfsr_next(lfsr);
        value = lfsr[0];
    endtask

    // Inputs change a little after the edge, never on it
    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic run_job(input int job);
        ptr_t  acc;
        int    nnz;
        int    chunks;
        int    chunk_base;
        logic  gap_a;
        logic  gap_b;
        logic  take;
        acc = '0;
        for (int i = 0; i < `SPMM_N; i++) begin
            acc = acc + ptr_t'(patterns[pat_pos + i]);
            lhs_ptr[i] = acc;
        end
        nnz = int'(acc);
        chunks = (nnz + `SPMM_N - 1) / `SPMM_N;
        pat_pos = pat_pos + `SPMM_N;
        chunk_base = pat_pos;
        pat_pos = pat_pos + 2 * `SPMM_N * chunks;
        for (int r = 0; r < `SPMM_N; r++) begin
            for (int c = 0; c < `SPMM_N; c++) begin
                rhs_mat[r][c] = patterns[pat_pos + r * `SPMM_N + c];
                expected[r][c] = patterns[pat_pos + `SPMM_N * `SPMM_N + r * `SPMM_N + c];
            end
        end
        pat_pos = pat_pos + 2 * `SPMM_N * `SPMM_N;
        job_num = job;

        while (!rhs_ready)
            next_cycle();
        // Start strobe goes with block 0 only
        for (int b = 0; b < `SPMM_NUM_BLOCKS; b++) begin
            rhs_start = (b == 0);
            for (int r = 0; r < `SPMM_BLOCK_ROWS; r++) begin
                for (int c = 0; c < `SPMM_N; c++) begin
                    rhs_data[r][c] = rhs_mat[b * `SPMM_BLOCK_ROWS + r][c];
                end
            end
            next_cycle();
        end
        rhs_start = 1'b0;

        while (!lhs_ready)
            next_cycle();
        for (int k = 0; k < chunks; k++) begin
            take_bit(gap_a);
            take_bit(gap_b);
            if (gap_a && gap_b) begin
                lhs_valid = 1'b0;
                next_cycle();
            end
            lhs_valid = 1'b1;
            for (int i = 0; i < `SPMM_N; i++) begin
                lhs_col[i] = idx_t'(patterns[chunk_base + 2 * `SPMM_N * k + i]);
                lhs_data[i] = patterns[chunk_base + 2 * `SPMM_N * k + `SPMM_N + i];
            end
            next_cycle();
        end
        lhs_valid = 1'b0;

        while (!out_ready)
            next_cycle();
        // Random holds on the output side
        while (out_ready) begin
            take_bit(take);
            out_start = take;
            next_cycle();
        end
        out_start = 1'b0;
    endtask

    initial begin
        lfsr = 32'hf32b_e2e8;
        pat_pos = 0;
        job_num = 0;
        reset = 1'b1;
        rhs_start = 1'b0;
        lhs_valid = 1'b0;
        out_start = 1'b0;
        rhs_data = '{default: '0};
        lhs_ptr = '{default: '0};
        lhs_col = '{default: '0};
        lhs_data = '{default: '0};
        expected = '{default: '0};
        $readmemh("testbench/spmm_patterns.hex", patterns);
        repeat (8) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        next_cycle();

        for (int j = 1; j <= NUM_JOBS; j++)
            run_job(j);
        repeat (3) next_cycle();

        $display("summary: %0d jobs, %0d blocks checked, %0d errors",
                 jobs_done, blocks_done, error_count);
        if (error_count == 0 && jobs_done == NUM_JOBS) begin
            $display("Everything OK");
        end else begin
            if (jobs_done != NUM_JOBS)
                $display("only %0d of %0d jobs delivered their output", jobs_done, NUM_JOBS);
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
